//--- Makefile
# Verilator build and run for the tone mixer testbench

VERILATOR ?= verilator
TOP       ?= tb_tone_mixer
OBJ_DIR   ?= obj_dir
FLAGS     ?= --binary -j 0

SOURCES := $(filter %.sv,$(shell cat filelist.f))
HEADERS := $(wildcard dv/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source, a header or the file list changes
$(BIN): filelist.f $(SOURCES) $(HEADERS)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f filelist.f

# fails unless the pass message shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^TEST PASSED$$'

clean:
	rm -rf $(OBJ_DIR)

//--- design/angle_fold.sv
// fold stage: first quadrant angle, amplitude magnitude and output sign flags

`timescale 1ns/1ps

module angle_fold (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic signed [tone_pkg::angle_width-1:0]  angle,
  input  logic signed [tone_pkg::sample_width-1:0] amplitude,
  input  logic                                   strobe_in,
  output logic signed [cordic_pkg::work_width-1:0] fold_angle,
  output logic        [tone_pkg::sample_width-1:0] magnitude,
  output logic                                   x_neg,
  output logic                                   y_neg,
  output logic                                   strobe_out
);

  import tone_pkg::*;
  import cordic_pkg::*;

  logic [angle_width-1:0]  abs_angle;
  logic [angle_width-1:0]  quad_angle;
  logic                    x_flip;
  logic                    amp_neg;
  logic [sample_width-1:0] amp_abs;

  ////////////////////////////////////////////////////////////////////
  // fold into 0..90 degrees
  ////////////////////////////////////////////////////////////////////

  // -180 comes out as 180 here, which then folds to 0
  assign abs_angle = angle[angle_width-1] ? angle_width'(-angle) : angle_width'(angle);

  always_comb begin
    if (abs_angle > angle_width'(quarter_turn)) begin
      quad_angle = angle_width'(half_turn) - abs_angle;
      x_flip     = 1'b1;
    end else begin
      quad_angle = abs_angle;
      x_flip     = 1'b0;
    end
  end

  // magnitude, -2048 gives 2048 which still fits unsigned
  assign amp_neg = amplitude[sample_width-1];
  assign amp_abs = amp_neg ? sample_width'(-amplitude) : sample_width'(amplitude);

  ////////////////////////////////////////////////////////////////////
  // stage register
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      strobe_out <= 1'b0;
    end else begin
      strobe_out <= strobe_in;
    end
  end

  // payload, no reset
  always_ff @(posedge clk) begin
    fold_angle <= work_width'(quad_angle) << frac_bits;
    magnitude  <= amp_abs;
    // quadrant sign, inverted again for a negative amplitude
    x_neg      <= x_flip ^ amp_neg;
    y_neg      <= angle[angle_width-1] ^ amp_neg;
  end

endmodule

//--- design/cordic_pkg.sv
// rotator arithmetic constants: iteration count, widths, gain compensation, arctangent table

package cordic_pkg;

  ////////////////////////////////////////////////////////////////////
  // iteration and fixed point sizing
  ////////////////////////////////////////////////////////////////////

  // number of micro-rotation stages
  localparam int iter_count = 16;

  // fraction bits carried through x, y and z
  localparam int frac_bits = 16;

  // x, y and angle register width, output width plus fraction
  localparam int work_width = 32;

  // 1/K scaled by 2^16, K being the gain of 16 rotations
  localparam logic [31:0] gain_comp = 32'd39797;

  ////////////////////////////////////////////////////////////////////
  // arctan(2^-i) in degrees, scaled by 2^16
  ////////////////////////////////////////////////////////////////////

  localparam logic [work_width-1:0] atan_table [0:iter_count-1] = '{
    32'd2949120,
    32'd1740967,
    32'd919879,
    32'd466945,
    32'd234379,
    32'd117304,
    32'd58666,
    32'd29335,
    32'd14668,
    32'd7334,
    32'd3667,
    32'd1833,
    32'd917,
    32'd458,
    32'd229,
    32'd115
  };

endpackage

//--- design/cordic_rotator.sv
// pipelined rotator: fold, gain preload, micro-rotation chain and sign-restoring output

`timescale 1ns/1ps

module cordic_rotator (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic signed [tone_pkg::angle_width-1:0]  angle,
  input  logic signed [tone_pkg::sample_width-1:0] amplitude,
  input  logic                                   strobe_in,
  output logic signed [tone_pkg::out_width-1:0]    cos_out,
  output logic signed [tone_pkg::out_width-1:0]    sin_out,
  output logic                                   result_strobe
);

  import tone_pkg::*;
  import cordic_pkg::*;

  logic signed [work_width-1:0] fold_angle;
  logic        [sample_width-1:0] magnitude;
  logic                         fold_x_neg;
  logic                         fold_y_neg;
  logic                         fold_strobe;

  // index 0 feeds the first stage, index iter_count leaves the last
  logic signed [work_width-1:0] x_pipe      [0:iter_count];
  logic signed [work_width-1:0] y_pipe      [0:iter_count];
  logic signed [work_width-1:0] z_pipe      [0:iter_count];
  logic signed [work_width-1:0] target_pipe [0:iter_count];
  logic                         x_neg_pipe  [0:iter_count];
  logic                         y_neg_pipe  [0:iter_count];
  logic                         strobe_pipe [0:iter_count];

  logic signed [out_width-1:0] x_final;
  logic signed [out_width-1:0] y_final;

  // magnitude times gain_comp, one shifted copy per set constant bit
  function automatic logic signed [work_width-1:0] gain_preload(
    input logic [sample_width-1:0] mag
  );
    logic [work_width-1:0] sum;
    sum = '0;
    for (int b = 0; b < frac_bits; b++) begin
      if (gain_comp[b]) begin
        sum = sum + (work_width'(mag) << b);
      end
    end
    return signed'(sum);
  endfunction

  angle_fold u_angle_fold (
    .clk        (clk),
    .rst_n      (rst_n),
    .angle      (angle),
    .amplitude  (amplitude),
    .strobe_in  (strobe_in),
    .fold_angle (fold_angle),
    .magnitude  (magnitude),
    .x_neg      (fold_x_neg),
    .y_neg      (fold_y_neg),
    .strobe_out (fold_strobe)
  );

  ////////////////////////////////////////////////////////////////////
  // preload, start at 0 degrees with x = |A| / K
  ////////////////////////////////////////////////////////////////////

  // shares the fold cycle, stage 0 registers it
  assign x_pipe[0]      = gain_preload(magnitude);
  assign y_pipe[0]      = '0;
  assign z_pipe[0]      = '0;
  assign target_pipe[0] = fold_angle;
  assign x_neg_pipe[0]  = fold_x_neg;
  assign y_neg_pipe[0]  = fold_y_neg;
  assign strobe_pipe[0] = fold_strobe;

  ////////////////////////////////////////////////////////////////////
  // micro-rotation chain
  ////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < iter_count; i++) begin : g_stage
    cordic_stage #(
      .stage (i)
    ) u_cordic_stage (
      .clk        (clk),
      .rst_n      (rst_n),
      .x_in       (x_pipe[i]),
      .y_in       (y_pipe[i]),
      .z_in       (z_pipe[i]),
      .target_in  (target_pipe[i]),
      .x_neg_in   (x_neg_pipe[i]),
      .y_neg_in   (y_neg_pipe[i]),
      .strobe_in  (strobe_pipe[i]),
      .x_out      (x_pipe[i+1]),
      .y_out      (y_pipe[i+1]),
      .z_out      (z_pipe[i+1]),
      .target_out (target_pipe[i+1]),
      .x_neg_out  (x_neg_pipe[i+1]),
      .y_neg_out  (y_neg_pipe[i+1]),
      .strobe_out (strobe_pipe[i+1])
    );
  end

  ////////////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////////////

  // drop the fraction bits
  assign x_final = out_width'(x_pipe[iter_count] >>> frac_bits);
  assign y_final = out_width'(y_pipe[iter_count] >>> frac_bits);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cos_out       <= '0;
      sin_out       <= '0;
      result_strobe <= 1'b0;
    end else begin
      result_strobe <= strobe_pipe[iter_count];
      // outputs hold between results
      if (strobe_pipe[iter_count]) begin
        // restore the quadrant, a zero stays zero
        cos_out <= (x_neg_pipe[iter_count] && x_final != '0) ? -x_final : x_final;
        sin_out <= (y_neg_pipe[iter_count] && y_final != '0) ? -y_final : y_final;
      end
    end
  end

endmodule

//--- design/cordic_stage.sv
// single CORDIC micro-rotation stage with target and sign side-band registers

`timescale 1ns/1ps

module cordic_stage #(
  parameter int stage = 0
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic signed [cordic_pkg::work_width-1:0] x_in,
  input  logic signed [cordic_pkg::work_width-1:0] y_in,
  input  logic signed [cordic_pkg::work_width-1:0] z_in,
  input  logic signed [cordic_pkg::work_width-1:0] target_in,
  input  logic                                   x_neg_in,
  input  logic                                   y_neg_in,
  input  logic                                   strobe_in,
  output logic signed [cordic_pkg::work_width-1:0] x_out,
  output logic signed [cordic_pkg::work_width-1:0] y_out,
  output logic signed [cordic_pkg::work_width-1:0] z_out,
  output logic signed [cordic_pkg::work_width-1:0] target_out,
  output logic                                   x_neg_out,
  output logic                                   y_neg_out,
  output logic                                   strobe_out
);

  import cordic_pkg::*;

  logic signed [work_width-1:0] z_diff;
  logic signed [work_width-1:0] x_shift;
  logic signed [work_width-1:0] y_shift;
  logic signed [work_width-1:0] step_angle;

  // accumulated angle minus target, sign picks the direction
  assign z_diff     = z_in - target_in;
  assign x_shift    = x_in >>> stage;
  assign y_shift    = y_in >>> stage;
  assign step_angle = signed'(atan_table[stage]);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      strobe_out <= 1'b0;
    end else begin
      strobe_out <= strobe_in;
    end
  end

  always_ff @(posedge clk) begin
    if (z_diff[work_width-1]) begin
      // still short of the target, rotate up
      x_out <= x_in - y_shift;
      y_out <= y_in + x_shift;
      z_out <= z_in + step_angle;
    end else begin
      x_out <= x_in + y_shift;
      y_out <= y_in - x_shift;
      z_out <= z_in - step_angle;
    end
    target_out <= target_in;
    x_neg_out  <= x_neg_in;
    y_neg_out  <= y_neg_in;
  end

endmodule

//--- design/phase_sweep.sv
// degree phase accumulator with modulo 360 wrap, pairs each sample with its angle

`timescale 1ns/1ps

module phase_sweep (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   phase_load,
  input  logic        [tone_pkg::angle_width-1:0]  phase_init,
  input  logic        [tone_pkg::angle_width-1:0]  phase_step,
  input  logic                                   sample_strobe,
  input  logic signed [tone_pkg::sample_width-1:0] sample,
  output logic signed [tone_pkg::angle_width-1:0]  angle,
  output logic signed [tone_pkg::sample_width-1:0] amplitude,
  output logic                                   pair_strobe
);

  import tone_pkg::*;

  // phase in 0..359
  logic [angle_width-1:0] phase_acc;
  logic [angle_width-1:0] phase_sum;
  logic [angle_width-1:0] phase_next;
  logic [angle_width-1:0] phase_signed;

  ////////////////////////////////////////////////////////////////////
  // next phase and signed view
  ////////////////////////////////////////////////////////////////////

  // both terms below 360, one subtraction is enough
  assign phase_sum  = phase_acc + phase_step;
  assign phase_next = (phase_sum >= angle_width'(full_turn)) ?
                      phase_sum - angle_width'(full_turn) : phase_sum;

  // 180..359 becomes -180..-1
  assign phase_signed = (phase_acc >= angle_width'(half_turn)) ?
                        phase_acc - angle_width'(full_turn) : phase_acc;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase_acc   <= '0;
      pair_strobe <= 1'b0;
    end else begin
      pair_strobe <= sample_strobe;
      // a load wins, the strobed sample still takes the old phase
      if (phase_load) begin
        phase_acc <= phase_init;
      end else if (sample_strobe) begin
        phase_acc <= phase_next;
      end
    end
  end

  // sample and angle pair
  always_ff @(posedge clk) begin
    if (sample_strobe) begin
      angle     <= signed'(phase_signed);
      amplitude <= sample;
    end
  end

endmodule

//--- design/tone_mixer_top.sv
// tone mixer top: phase sweep feeding the CORDIC rotator

`timescale 1ns/1ps

module tone_mixer_top (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic signed [tone_pkg::sample_width-1:0] sample,
  input  logic                                   sample_strobe,
  input  logic                                   phase_load,
  input  logic        [tone_pkg::angle_width-1:0]  phase_init,
  input  logic        [tone_pkg::angle_width-1:0]  phase_step,
  output logic signed [tone_pkg::out_width-1:0]    cos_out,
  output logic signed [tone_pkg::out_width-1:0]    sin_out,
  output logic                                   result_strobe
);

  import tone_pkg::*;

  // sweep to rotator
  logic signed [angle_width-1:0]  angle;
  logic signed [sample_width-1:0] amplitude;
  logic                           pair_strobe;

  phase_sweep u_phase_sweep (
    .clk           (clk),
    .rst_n         (rst_n),
    .phase_load    (phase_load),
    .phase_init    (phase_init),
    .phase_step    (phase_step),
    .sample_strobe (sample_strobe),
    .sample        (sample),
    .angle         (angle),
    .amplitude     (amplitude),
    .pair_strobe   (pair_strobe)
  );

  cordic_rotator u_cordic_rotator (
    .clk           (clk),
    .rst_n         (rst_n),
    .angle         (angle),
    .amplitude     (amplitude),
    .strobe_in     (pair_strobe),
    .cos_out       (cos_out),
    .sin_out       (sin_out),
    .result_strobe (result_strobe)
  );

endmodule

//--- design/tone_pkg.sv
// mixer port widths and angle range constants in whole degrees

package tone_pkg;

  // signed input amplitude
  localparam int sample_width = 12;

  // signed angle in degrees, legal range -180 to 179
  localparam int angle_width = 16;

  // signed cosine and sine result width
  localparam int out_width = 16;

  ////////////////////////////////////////////////////////////////////
  // angle range in degrees
  ////////////////////////////////////////////////////////////////////

  // one full revolution, phase wraps here
  localparam int full_turn = 360;

  // start of the negative half of the circle
  localparam int half_turn = 180;

  // first quadrant limit
  localparam int quarter_turn = 90;

endpackage

//--- dv/rotation_model.svh
// reference model for the tone mixer: phase tracking, expected-result queue, tolerance check
`ifndef rotation_model_svh
`define rotation_model_svh

  localparam real deg_to_rad = 3.14159265358979 / 180.0;

  // allowed distance from the truncated real result, in LSB
  localparam int tolerance = 2;

  // model phase, kept in 0..359 like the accumulator
  int model_phase;

  // one entry per strobed sample, oldest first
  int exp_cos   [$];
  int exp_sin   [$];
  int exp_angle [$];
  int exp_amp   [$];
  int exp_cycle [$];

  // 180..359 shows up as -180..-1 on the angle bus
  function automatic int to_signed_angle(input int phase);
    if (phase >= half_turn) begin
      return phase - full_turn;
    end
    return phase;
  endfunction

  // A cos or A sin in real arithmetic, truncated toward zero
  function automatic int trunc_rotate(input int amp, input int angle, input bit want_sin);
    real prod;
    if (want_sin) begin
      prod = amp * $sin(angle * deg_to_rad);
    end else begin
      prod = amp * $cos(angle * deg_to_rad);
    end
    return $rtoi(prod);
  endfunction

  function automatic bit within_tol(input int expected, input int actual);
    return ((actual - expected) <= tolerance) && ((expected - actual) <= tolerance);
  endfunction

  // one input cycle as the phase sweep sees it
  task automatic model_cycle(input bit strobe, input int amp, input bit load,
                             input int init, input int step, input int cycle);
    int angle;
    if (strobe) begin
      // the strobed sample always takes the phase held before this cycle
      angle = to_signed_angle(model_phase);
      exp_cos.push_back(trunc_rotate(amp, angle, 1'b0));
      exp_sin.push_back(trunc_rotate(amp, angle, 1'b1));
      exp_angle.push_back(angle);
      exp_amp.push_back(amp);
      exp_cycle.push_back(cycle);
    end
    if (load) begin
      model_phase = init;
    end else if (strobe) begin
      model_phase = (model_phase + step) % full_turn;
    end
  endtask

`endif

//--- dv/tb_tone_mixer.sv
// tone mixer testbench with clock, reset, random stimulus, result checks and report

`timescale 1ns/1ps

module tb_tone_mixer;

  import tone_pkg::*;

  // sample_strobe to result_strobe in clock cycles
  localparam int latency     = 19;
  localparam int drain_limit = 200;

  // starts low so no falling edge is seen at time zero
  logic                           clk = 1'b0;
  logic                           rst_n;
  logic signed [sample_width-1:0] sample;
  logic                           sample_strobe;
  logic                           phase_load;
  logic        [angle_width-1:0]  phase_init;
  logic        [angle_width-1:0]  phase_step;
  logic signed [out_width-1:0]    cos_out;
  logic signed [out_width-1:0]    sin_out;
  logic                           result_strobe;

  int seed;
  int cycle_cnt;
  int value_errors;
  int latency_errors;
  int protocol_errors;
  int checked;
  bit result_seen;

  int edge_angles [5] = '{0, 90, 179, 180, 270};
  int edge_amps   [5] = '{2047, -2048, 1365, -1, 0};

  `include "rotation_model.svh"

  tone_mixer_top u_tone_mixer_top (
    .clk           (clk),
    .rst_n         (rst_n),
    .sample        (sample),
    .sample_strobe (sample_strobe),
    .phase_load    (phase_load),
    .phase_init    (phase_init),
    .phase_step    (phase_step),
    .cos_out       (cos_out),
    .sin_out       (sin_out),
    .result_strobe (result_strobe)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  function automatic int pick_range(input int lo, input int hi);
    int span;
    span = hi - lo + 1;
    return lo + int'($unsigned($random(seed)) % span);
  endfunction

  // mostly uniform with the extremes and zero mixed in
  function automatic int pick_amplitude();
    int sel;
    sel = pick_range(0, 15);
    case (sel)
      0:       return -2048;
      1:       return 2047;
      2:       return 0;
      default: return pick_range(-2048, 2047);
    endcase
  endfunction

  // inputs change on the falling edge only
  task automatic drive_cycle(input bit strobe, input int amp, input bit load,
                             input int init, input int step);
    @(negedge clk);
    sample_strobe = strobe;
    sample        = sample_width'(amp);
    phase_load    = load;
    phase_init    = angle_width'(init);
    phase_step    = angle_width'(step);
    model_cycle(strobe, amp, load, init, step, cycle_cnt);
  endtask

  task automatic check_result();
    int want_cos;
    int want_sin;
    int angle;
    int amp;
    int issued;
    result_seen = 1'b1;
    if (exp_cos.size() == 0) begin
      protocol_errors++;
      $display("result strobe at %0t with no sample waiting for it", $time);
    end else begin
      want_cos = exp_cos.pop_front();
      want_sin = exp_sin.pop_front();
      angle    = exp_angle.pop_front();
      amp      = exp_amp.pop_front();
      issued   = exp_cycle.pop_front();
      checked++;
      if (cycle_cnt - issued != latency) begin
        latency_errors++;
        $display("mismatch at %0t: latency expected %0d, actual %0d",
                 $time, latency, cycle_cnt - issued);
      end
      if (!within_tol(want_cos, int'(cos_out))) begin
        value_errors++;
        $display("mismatch at %0t: cos A=%0d angle=%0d expected %0d, actual %0d",
                 $time, amp, angle, want_cos, cos_out);
      end
      if (!within_tol(want_sin, int'(sin_out))) begin
        value_errors++;
        $display("mismatch at %0t: sin A=%0d angle=%0d expected %0d, actual %0d",
                 $time, amp, angle, want_sin, sin_out);
      end
    end
  endtask

  task automatic report_counts();
    $display("errors: value %0d, latency %0d, protocol %0d, results checked %0d",
             value_errors, latency_errors, protocol_errors, checked);
  endtask

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    if (result_strobe) begin
      check_result();
    end else if (!result_seen && (cos_out !== '0 || sin_out !== '0)) begin
      protocol_errors++;
      $display("outputs not zero before the first result at %0t", $time);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    bit strobe_bit;
    bit load_bit;
    int sweep_step;
    int wait_cycles;
    seed            = 32'hecc3_8755;
    rst_n           = 1'b0;
    sample          = '0;
    sample_strobe   = 1'b0;
    phase_load      = 1'b0;
    phase_init      = '0;
    phase_step      = '0;
    cycle_cnt       = 0;
    value_errors    = 0;
    latency_errors  = 0;
    protocol_errors = 0;
    checked         = 0;
    result_seen     = 1'b0;
    model_phase     = 0;

    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // quiet outputs after reset
    for (int n = 0; n < 8; n++) begin
      drive_cycle(1'b0, 0, 1'b0, 0, 0);
    end

    // fixed angle per sample across all quadrants
    for (int n = 0; n < 60; n++) begin
      drive_cycle(1'b0, 0, 1'b1, pick_range(0, full_turn - 1), 0);
      drive_cycle(1'b1, pick_amplitude(), 1'b0, 0, 0);
    end

    // edge angles with back to back samples per angle
    for (int a = 0; a < 5; a++) begin
      drive_cycle(1'b0, 0, 1'b1, edge_angles[a], 0);
      for (int m = 0; m < 5; m++) begin
        drive_cycle(1'b1, edge_amps[m], 1'b0, 0, 0);
      end
    end

    // load together with a strobe takes effect on the next sample
    for (int n = 0; n < 12; n++) begin
      drive_cycle(1'b1, pick_amplitude(), 1'b1, pick_range(0, full_turn - 1),
                  pick_range(0, full_turn - 1));
      drive_cycle(1'b1, pick_amplitude(), 1'b0, 0, pick_range(0, full_turn - 1));
    end

    // random sweeps with gaps and occasional loads
    sweep_step = pick_range(0, full_turn - 1);
    for (int n = 0; n < 400; n++) begin
      if (pick_range(0, 31) == 0) begin
        sweep_step = pick_range(0, full_turn - 1);
      end
      strobe_bit = (pick_range(0, 3) != 0);
      load_bit   = (pick_range(0, 24) == 0);
      drive_cycle(strobe_bit, pick_amplitude(), load_bit, pick_range(0, full_turn - 1),
                  sweep_step);
    end

    drive_cycle(1'b0, 0, 1'b0, 0, 0);
    wait_cycles = 0;
    while (exp_cos.size() != 0 && wait_cycles < drain_limit) begin
      @(negedge clk);
      wait_cycles++;
    end

    if (exp_cos.size() != 0) begin
      $display("timeout while waiting for %0d outstanding results", exp_cos.size());
      report_counts();
      $display("TEST FAILED");
    end else begin
      // any late strobe now meets an empty queue
      repeat (latency + 6) @(negedge clk);
      report_counts();
      if (value_errors + latency_errors + protocol_errors == 0 && checked > 0) begin
        $display("TEST PASSED");
      end else begin
        $display("TEST FAILED");
      end
    end
    $finish;
  end

endmodule

//--- filelist.f
+incdir+dv
design/cordic_pkg.sv
design/tone_pkg.sv
design/angle_fold.sv
design/cordic_stage.sv
design/cordic_rotator.sv
design/phase_sweep.sv
design/tone_mixer_top.sv
dv/tb_tone_mixer.sv
